// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        := tb_rr_csrs
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
+incdir+.
rr_axil_pkg.sv
rr_csr_pkg.sv
rr_csr_pipe.sv
rr_cfg_write_port.sv
rr_cfg_read_port.sv
rr_csr_file.sv
rr_csrs.sv
rr_csrs_properties.sv
tb_rr_csrs.sv

// ==== rr_axil_pkg.sv ====
package rr_axil_pkg;

    // bus byte address, data, byte strobe and response
    typedef logic [31:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0] axil_strb_t;
    typedef logic [1:0] axil_resp_t;

    // write port: which half of a write is held, or a response is pending
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_HAVE_AW,
        WR_HAVE_W,
        WR_RESP
    } wr_state_e;

endpackage

// ==== rr_cfg_read_port.sv ====
`include "rr_csr_defines.svh"

module rr_cfg_read_port (
    input  logic                    clk,
    input  logic                    rstn,
    input  rr_axil_pkg::axil_addr_t araddr_i,
    input  logic                    arvalid_i,
    input  logic                    rready_i,
    input  rr_csr_pkg::csr_word_t   rd_word_i,
    output logic                    arready_o,
    output logic                    rvalid_o,
    output rr_axil_pkg::axil_data_t rdata_o,
    output rr_csr_pkg::csr_idx_t    rd_idx_o
);

    logic ar_fire;

    // one read in flight, the next waits until the data is taken
    assign arready_o = !(rvalid_o && !rready_i);
    assign ar_fire   = arvalid_i && arready_o;
    assign rd_idx_o  = araddr_i[2 +: `RR_CSR_ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rvalid_o <= 1'b0;
        end else if (ar_fire) begin
            rvalid_o <= 1'b1;
        end else if (rready_i) begin
            rvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata_o <= rd_word_i;
        end
    end

endmodule

// ==== rr_cfg_write_port.sv ====
`include "rr_csr_defines.svh"

module rr_cfg_write_port (
    input  logic                    clk,
    input  logic                    rstn,
    input  rr_axil_pkg::axil_addr_t awaddr_i,
    input  logic                    awvalid_i,
    input  rr_axil_pkg::axil_data_t wdata_i,
    input  rr_axil_pkg::axil_strb_t wstrb_i,
    input  logic                    wvalid_i,
    input  logic                    bready_i,
    output logic                    awready_o,
    output logic                    wready_o,
    output logic                    bvalid_o,
    output logic                    wr_en_o,
    output rr_csr_pkg::csr_idx_t    wr_idx_o,
    output rr_csr_pkg::csr_word_t   wr_data_o,
    output rr_axil_pkg::axil_strb_t wr_strb_o
);

    rr_axil_pkg::wr_state_e state_q;
    rr_axil_pkg::wr_state_e state_d;
    logic aw_fire;
    logic w_fire;
    logic pair_done;
    logic resp_stall;

    // a pending response only blocks new beats while the host holds it off
    assign resp_stall = (state_q == rr_axil_pkg::WR_RESP) && !bready_i;
    assign awready_o  = (state_q != rr_axil_pkg::WR_HAVE_AW) && !resp_stall;
    assign wready_o   = (state_q != rr_axil_pkg::WR_HAVE_W) && !resp_stall;
    assign bvalid_o   = (state_q == rr_axil_pkg::WR_RESP);

    assign aw_fire = awvalid_i && awready_o;
    assign w_fire  = wvalid_i && wready_o;

    // both halves present, either held or arriving now
    assign pair_done = (aw_fire || state_q == rr_axil_pkg::WR_HAVE_AW) &&
                       (w_fire || state_q == rr_axil_pkg::WR_HAVE_W);

    always_comb begin
        state_d = state_q;
        if (pair_done) begin
            state_d = rr_axil_pkg::WR_RESP;
        end else if (aw_fire) begin
            state_d = rr_axil_pkg::WR_HAVE_AW;
        end else if (w_fire) begin
            state_d = rr_axil_pkg::WR_HAVE_W;
        end else if (state_q == rr_axil_pkg::WR_RESP && bready_i) begin
            state_d = rr_axil_pkg::WR_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= rr_axil_pkg::WR_IDLE;
            wr_en_o <= 1'b0;
        end else begin
            state_q <= state_d;
            wr_en_o <= pair_done;
        end
    end

    // word-aligned address, low two bits dropped
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_idx_o <= awaddr_i[2 +: `RR_CSR_ADDR_WIDTH];
        end
        if (w_fire) begin
            wr_data_o <= wdata_i;
            wr_strb_o <= wstrb_i;
        end
    end

endmodule

// ==== rr_csr_defines.svh ====
`ifndef RR_CSR_DEFINES_SVH
`define RR_CSR_DEFINES_SVH

// register index width and register count
`define RR_CSR_ADDR_WIDTH 5
`define RR_CSR_CNT 32

// writable control registers
`define RR_MODE 0
`define BUF_ADDR_LO 1
`define BUF_ADDR_HI 2
`define BUF_SIZE_LO 3
`define BUF_SIZE_HI 4
`define REPLAY_BITS_LO 5
`define REPLAY_BITS_HI 6

// command addresses, a write here gives a one cycle pulse
`define RECORD_BUF_UPDATE 7
`define REPLAY_BUF_UPDATE 8
`define RECORD_FORCE_FINISH 9
`define VALIDATE_BUF_UPDATE 10

`define RR_ON_THE_FLY_BALANCE 11

// read-only words
`define RR_CSR_VERSION 12
`define RECORD_BITS_LO 13
`define RECORD_BITS_HI 14
`define VALIDATE_BITS_LO 15
`define VALIDATE_BITS_HI 16
`define RT_REPLAY_BITS_LO 17
`define RT_REPLAY_BITS_HI 18
`define RR_STATE_LO 19
`define RR_STATE_HI 20

`define RR_CSR_VERSION_VAL 32'h0001_0002
`define RR_BALANCE_RESET 32'd100

// register stages on status inputs and control outputs
`define RR_REG_STAGES_DEFAULT 1

`endif

// ==== rr_csr_file.sv ====
`include "rr_csr_defines.svh"

module rr_csr_file (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    wr_en_i,
    input  rr_csr_pkg::csr_idx_t    wr_idx_i,
    input  rr_csr_pkg::csr_word_t   wr_data_i,
    input  rr_axil_pkg::axil_strb_t wr_strb_i,
    input  rr_csr_pkg::csr_idx_t    rd_idx_i,
    input  rr_csr_pkg::csr_wide_t   record_bits_i,
    input  rr_csr_pkg::csr_wide_t   validate_bits_i,
    input  rr_csr_pkg::csr_wide_t   rt_replay_bits_i,
    input  rr_csr_pkg::csr_wide_t   rr_state_i,
    output rr_csr_pkg::csr_word_t   rd_word_o,
    output logic [2:0]              mode_o,
    output rr_csr_pkg::csr_wide_t   buf_addr_o,
    output rr_csr_pkg::csr_wide_t   buf_size_o,
    output rr_csr_pkg::csr_wide_t   replay_bits_o,
    output rr_csr_pkg::csr_word_t   balance_o,
    output logic [3:0]              cmd_pulse_o
);

    rr_csr_pkg::csr_word_t csrs [`RR_CSR_CNT];
    rr_csr_pkg::csr_word_t bit_mask;
    rr_csr_pkg::csr_word_t merge_q;
    rr_csr_pkg::csr_idx_t  merge_idx_q;
    logic                  merge_vld_q;

    // byte strobes widened to a bit mask
    always_comb begin
        for (int b = 0; b < $bits(wr_strb_i); b++) begin
            bit_mask[8*b +: 8] = {8{wr_strb_i[b]}};
        end
    end

    // first stage: merge new bytes into the old word
    always_ff @(posedge clk) begin
        if (!rstn) begin
            merge_vld_q <= 1'b0;
        end else begin
            merge_vld_q <= wr_en_i;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            merge_q     <= (wr_data_i & bit_mask) | (csrs[wr_idx_i] & ~bit_mask);
            merge_idx_q <= wr_idx_i;
        end
    end

    // second stage: store, then refresh the read-only words
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < `RR_CSR_CNT; i++) begin
                csrs[i] <= '0;
            end
            csrs[`RR_ON_THE_FLY_BALANCE] <= `RR_BALANCE_RESET;
            csrs[`RR_CSR_VERSION]        <= `RR_CSR_VERSION_VAL;
        end else begin
            if (merge_vld_q && merge_idx_q <= `RR_ON_THE_FLY_BALANCE) begin
                csrs[merge_idx_q] <= merge_q;
            end
            csrs[`RR_CSR_VERSION]    <= `RR_CSR_VERSION_VAL;
            csrs[`RECORD_BITS_LO]    <= record_bits_i[31:0];
            csrs[`RECORD_BITS_HI]    <= record_bits_i[63:32];
            csrs[`VALIDATE_BITS_LO]  <= validate_bits_i[31:0];
            csrs[`VALIDATE_BITS_HI]  <= validate_bits_i[63:32];
            csrs[`RT_REPLAY_BITS_LO] <= rt_replay_bits_i[31:0];
            csrs[`RT_REPLAY_BITS_HI] <= rt_replay_bits_i[63:32];
            csrs[`RR_STATE_LO]       <= rr_state_i[31:0];
            csrs[`RR_STATE_HI]       <= rr_state_i[63:32];
        end
    end

    // indices past the status words are not backed
    assign rd_word_o = (rd_idx_i > `RR_STATE_HI) ? '0 : csrs[rd_idx_i];

    assign mode_o        = csrs[`RR_MODE][2:0];
    assign buf_addr_o    = {csrs[`BUF_ADDR_HI], csrs[`BUF_ADDR_LO]};
    assign buf_size_o    = {csrs[`BUF_SIZE_HI], csrs[`BUF_SIZE_LO]};
    assign replay_bits_o = {csrs[`REPLAY_BITS_HI], csrs[`REPLAY_BITS_LO]};
    assign balance_o     = csrs[`RR_ON_THE_FLY_BALANCE];

    // pulses come from the strobe itself, a cycle ahead of the merge
    assign cmd_pulse_o[0] = wr_en_i && (wr_idx_i == `RECORD_BUF_UPDATE);
    assign cmd_pulse_o[1] = wr_en_i && (wr_idx_i == `REPLAY_BUF_UPDATE);
    assign cmd_pulse_o[2] = wr_en_i && (wr_idx_i == `RECORD_FORCE_FINISH);
    assign cmd_pulse_o[3] = wr_en_i && (wr_idx_i == `VALIDATE_BUF_UPDATE);

endmodule

// ==== rr_csr_pipe.sv ====
module rr_csr_pipe #(
    parameter int WIDTH  = 32,
    parameter int STAGES = 1
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic [WIDTH-1:0] in_i,
    output logic [WIDTH-1:0] out_o
);

    logic [WIDTH-1:0] stage_q [STAGES];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < STAGES; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= in_i;
            for (int i = 1; i < STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign out_o = stage_q[STAGES-1];

endmodule

// ==== rr_csr_pkg.sv ====
`include "rr_csr_defines.svh"

package rr_csr_pkg;

    // register index inside the block
    typedef logic [`RR_CSR_ADDR_WIDTH-1:0] csr_idx_t;

    // one register word
    typedef logic [31:0] csr_word_t;

    // 64-bit value kept in a LO/HI register pair
    typedef logic [63:0] csr_wide_t;

endpackage

// ==== rr_csrs.sv ====
`include "rr_csr_defines.svh"

module rr_csrs #(
    parameter int REG_STAGES = `RR_REG_STAGES_DEFAULT
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  rr_axil_pkg::axil_addr_t s_awaddr_i,
    input  logic                    s_awvalid_i,
    input  rr_axil_pkg::axil_data_t s_wdata_i,
    input  rr_axil_pkg::axil_strb_t s_wstrb_i,
    input  logic                    s_wvalid_i,
    input  logic                    s_bready_i,
    input  rr_axil_pkg::axil_addr_t s_araddr_i,
    input  logic                    s_arvalid_i,
    input  logic                    s_rready_i,
    input  rr_csr_pkg::csr_wide_t   record_bits_i,
    input  rr_csr_pkg::csr_wide_t   validate_bits_i,
    input  rr_csr_pkg::csr_wide_t   rt_replay_bits_i,
    input  rr_csr_pkg::csr_wide_t   rr_state_i,
    output logic                    s_awready_o,
    output logic                    s_wready_o,
    output logic                    s_bvalid_o,
    output rr_axil_pkg::axil_resp_t s_bresp_o,
    output logic                    s_arready_o,
    output logic                    s_rvalid_o,
    output rr_axil_pkg::axil_data_t s_rdata_o,
    output rr_axil_pkg::axil_resp_t s_rresp_o,
    output logic                    record_en_o,
    output logic                    replay_en_o,
    output logic                    validate_en_o,
    output rr_csr_pkg::csr_wide_t   buf_addr_o,
    output rr_csr_pkg::csr_wide_t   buf_size_o,
    output rr_csr_pkg::csr_wide_t   replay_bits_o,
    output rr_csr_pkg::csr_word_t   on_the_fly_balance_o,
    output logic                    write_buf_update_o,
    output logic                    read_buf_update_o,
    output logic                    record_force_finish_o,
    output logic                    validate_buf_update_o
);

    localparam int STAT_W = 4 * $bits(rr_csr_pkg::csr_wide_t);
    localparam int CTRL_W = 3 + 3 * $bits(rr_csr_pkg::csr_wide_t) +
                            $bits(rr_csr_pkg::csr_word_t) + 4;

    logic                    wr_en;
    rr_csr_pkg::csr_idx_t    wr_idx;
    rr_csr_pkg::csr_word_t   wr_data;
    rr_axil_pkg::axil_strb_t wr_strb;
    rr_csr_pkg::csr_idx_t    rd_idx;
    rr_csr_pkg::csr_word_t   rd_word;
    rr_csr_pkg::csr_wide_t   record_bits_s;
    rr_csr_pkg::csr_wide_t   validate_bits_s;
    rr_csr_pkg::csr_wide_t   rt_replay_bits_s;
    rr_csr_pkg::csr_wide_t   rr_state_s;
    logic [2:0]              mode;
    rr_csr_pkg::csr_wide_t   buf_addr;
    rr_csr_pkg::csr_wide_t   buf_size;
    rr_csr_pkg::csr_wide_t   replay_bits;
    rr_csr_pkg::csr_word_t   balance;
    logic [3:0]              cmd_pulse;
    logic [STAT_W-1:0]       stat_in;
    logic [STAT_W-1:0]       stat_out;
    logic [CTRL_W-1:0]       ctrl_in;
    logic [CTRL_W-1:0]       ctrl_out;

    // responses are always OKAY
    assign s_bresp_o = 2'b00;
    assign s_rresp_o = 2'b00;

    rr_cfg_write_port u_write_port (
        .clk(clk), .rstn(rstn),
        .awaddr_i(s_awaddr_i), .awvalid_i(s_awvalid_i),
        .wdata_i(s_wdata_i), .wstrb_i(s_wstrb_i), .wvalid_i(s_wvalid_i),
        .bready_i(s_bready_i),
        .awready_o(s_awready_o), .wready_o(s_wready_o), .bvalid_o(s_bvalid_o),
        .wr_en_o(wr_en), .wr_idx_o(wr_idx), .wr_data_o(wr_data), .wr_strb_o(wr_strb)
    );

    rr_cfg_read_port u_read_port (
        .clk(clk), .rstn(rstn),
        .araddr_i(s_araddr_i), .arvalid_i(s_arvalid_i), .rready_i(s_rready_i),
        .rd_word_i(rd_word),
        .arready_o(s_arready_o), .rvalid_o(s_rvalid_o), .rdata_o(s_rdata_o),
        .rd_idx_o(rd_idx)
    );

    // status inputs staged before capture
    assign stat_in = {record_bits_i, validate_bits_i, rt_replay_bits_i, rr_state_i};
    assign {record_bits_s, validate_bits_s, rt_replay_bits_s, rr_state_s} = stat_out;

    rr_csr_pipe #(.WIDTH(STAT_W), .STAGES(REG_STAGES)) u_stat_pipe (
        .clk(clk), .rstn(rstn), .in_i(stat_in), .out_o(stat_out)
    );

    rr_csr_file u_csr_file (
        .clk(clk), .rstn(rstn),
        .wr_en_i(wr_en), .wr_idx_i(wr_idx), .wr_data_i(wr_data), .wr_strb_i(wr_strb),
        .rd_idx_i(rd_idx),
        .record_bits_i(record_bits_s), .validate_bits_i(validate_bits_s),
        .rt_replay_bits_i(rt_replay_bits_s), .rr_state_i(rr_state_s),
        .rd_word_o(rd_word), .mode_o(mode),
        .buf_addr_o(buf_addr), .buf_size_o(buf_size), .replay_bits_o(replay_bits),
        .balance_o(balance), .cmd_pulse_o(cmd_pulse)
    );

    // control fields and command pulses share one output stage
    assign ctrl_in = {mode, buf_addr, buf_size, replay_bits, balance, cmd_pulse};
    assign {validate_en_o, replay_en_o, record_en_o,
            buf_addr_o, buf_size_o, replay_bits_o, on_the_fly_balance_o,
            validate_buf_update_o, record_force_finish_o,
            read_buf_update_o, write_buf_update_o} = ctrl_out;

    rr_csr_pipe #(.WIDTH(CTRL_W), .STAGES(REG_STAGES)) u_ctrl_pipe (
        .clk(clk), .rstn(rstn), .in_i(ctrl_in), .out_o(ctrl_out)
    );

endmodule

// ==== rr_csrs_properties.sv ====
module rr_csrs_properties (
    input logic        clk,
    input logic        rstn,
    input logic        bvalid_i,
    input logic        bready_i,
    input logic        rvalid_i,
    input logic        rready_i,
    input logic [31:0] rdata_i,
    input logic [3:0]  pulse_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // a response stays up until the host takes it
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
        bvalid_i && !bready_i |=> bvalid_i)
        else $error("write response valid dropped before bready");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
        rvalid_i && !rready_i |=> rvalid_i)
        else $error("read data valid dropped before rready");

    a_rdata_stable: assert property (@(posedge clk) disable iff (!rstn)
        rvalid_i && !rready_i |=> $stable(rdata_i))
        else $error("read data changed while waiting for rready");

    // command outputs are mutually exclusive
    a_one_pulse: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(pulse_i))
        else $error("more than one command pulse high");

endmodule

// ==== tb_rr_csrs.sv ====
`include "rr_csr_defines.svh"

module tb_rr_csrs;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_RAND          = 150;
    localparam int N_TESTS         = N_RAND + 100;
    localparam int CYCLES_PER_TEST = 40;
    localparam int WATCHDOG_CYCLES = N_TESTS * CYCLES_PER_TEST;

    logic                  clk;
    logic                  rstn;
    logic [31:0]           awaddr;
    logic                  awvalid;
    logic [31:0]           wdata;
    logic [3:0]            wstrb;
    logic                  wvalid;
    logic                  bready;
    logic [31:0]           araddr;
    logic                  arvalid;
    logic                  rready;
    rr_csr_pkg::csr_wide_t status [4];
    logic                  awready;
    logic                  wready;
    logic                  bvalid;
    logic [1:0]            bresp;
    logic                  arready;
    logic                  rvalid;
    logic [31:0]           rdata;
    logic [1:0]            rresp;
    logic                  record_en;
    logic                  replay_en;
    logic                  validate_en;
    rr_csr_pkg::csr_wide_t buf_addr;
    rr_csr_pkg::csr_wide_t buf_size;
    rr_csr_pkg::csr_wide_t replay_bits;
    rr_csr_pkg::csr_word_t balance;
    logic [3:0]            cmd_pulse;

    logic [31:0] model [12];
    logic [31:0] exp_rd_q [$];
    int          exp_idx_q [$];
    logic [3:0]  exp_pulse_q [$];
    logic [31:0] rand_state = 32'd55;
    logic        bp_en;
    int          checks;
    int          errors;

    rr_csrs #(.REG_STAGES(1)) UUT (
        .clk(clk), .rstn(rstn),
        .s_awaddr_i(awaddr), .s_awvalid_i(awvalid), .s_wdata_i(wdata), .s_wstrb_i(wstrb),
        .s_wvalid_i(wvalid), .s_bready_i(bready), .s_araddr_i(araddr),
        .s_arvalid_i(arvalid), .s_rready_i(rready),
        .record_bits_i(status[0]), .validate_bits_i(status[1]),
        .rt_replay_bits_i(status[2]), .rr_state_i(status[3]),
        .s_awready_o(awready), .s_wready_o(wready), .s_bvalid_o(bvalid), .s_bresp_o(bresp),
        .s_arready_o(arready), .s_rvalid_o(rvalid), .s_rdata_o(rdata), .s_rresp_o(rresp),
        .record_en_o(record_en), .replay_en_o(replay_en), .validate_en_o(validate_en),
        .buf_addr_o(buf_addr), .buf_size_o(buf_size), .replay_bits_o(replay_bits),
        .on_the_fly_balance_o(balance),
        .write_buf_update_o(cmd_pulse[0]), .read_buf_update_o(cmd_pulse[1]),
        .record_force_finish_o(cmd_pulse[2]), .validate_buf_update_o(cmd_pulse[3])
    );

    bind rr_csrs rr_csrs_properties u_props (
        .clk(clk), .rstn(rstn),
        .bvalid_i(s_bvalid_o), .bready_i(s_bready_i),
        .rvalid_i(s_rvalid_o), .rready_i(s_rready_i), .rdata_i(s_rdata_o),
        .pulse_i({validate_buf_update_o, record_force_finish_o,
                  read_buf_update_o, write_buf_update_o})
    );

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic [31:0] merge_word(input logic [31:0] old,
                                               input logic [31:0] data,
                                               input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [31:0] expect_read(input int idx);
        rr_csr_pkg::csr_wide_t wide;
        if (idx <= `RR_ON_THE_FLY_BALANCE) begin
            return model[idx];
        end
        if (idx == `RR_CSR_VERSION) begin
            return `RR_CSR_VERSION_VAL;
        end
        if (idx > `RR_STATE_HI) begin
            return 32'h0;
        end
        // status pairs, LO at the odd index
        wide = status[(idx - `RECORD_BITS_LO) / 2];
        return ((idx - `RECORD_BITS_LO) % 2 == 1) ? wide[63:32] : wide[31:0];
    endfunction

    function automatic logic [63:0] expect_pair(input int lo);
        return {model[lo + 1], model[lo]};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_ctrl();
        check_value("mode bits", 64'({validate_en, replay_en, record_en}),
                    64'(model[`RR_MODE][2:0]));
        check_value("buf_addr_o", buf_addr, expect_pair(`BUF_ADDR_LO));
        check_value("buf_size_o", buf_size, expect_pair(`BUF_SIZE_LO));
        check_value("replay_bits_o", replay_bits, expect_pair(`REPLAY_BITS_LO));
        check_value("on_the_fly_balance_o", 64'(balance),
                    64'(model[`RR_ON_THE_FLY_BALANCE]));
    endtask

    // order 0 sends both channels together, 1 address first, 2 data first
    task automatic axi_write(input int idx, input logic [31:0] data,
                             input logic [3:0] strb, input int order);
        logic aw_left;
        logic w_left;
        logic aw_hs;
        logic w_hs;
        aw_left = 1'b1;
        w_left  = 1'b1;
        @(posedge clk);
        if (order != 2) begin
            awaddr  <= idx << 2;
            awvalid <= 1'b1;
        end
        if (order != 1) begin
            wdata  <= data;
            wstrb  <= strb;
            wvalid <= 1'b1;
        end
        while (aw_left || w_left) begin
            @(negedge clk);
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            @(posedge clk);
            if (aw_hs) begin
                aw_left = 1'b0;
                awvalid <= 1'b0;
            end
            if (w_hs) begin
                w_left = 1'b0;
                wvalid <= 1'b0;
            end
            if (aw_hs && w_left) begin
                wdata  <= data;
                wstrb  <= strb;
                wvalid <= 1'b1;
            end
            if (w_hs && aw_left) begin
                awaddr  <= idx << 2;
                awvalid <= 1'b1;
            end
        end
        // this edge is E0
        if (idx <= `RR_ON_THE_FLY_BALANCE) begin
            model[idx] = merge_word(model[idx], data, strb);
        end
        if (idx >= `RECORD_BUF_UPDATE && idx <= `VALIDATE_BUF_UPDATE) begin
            exp_pulse_q.push_back(4'b0001 << (idx - `RECORD_BUF_UPDATE));
        end
        do @(negedge clk); while (!(bvalid && bready));
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_ctrl();
    endtask

    task automatic axi_read(input int idx);
        @(posedge clk);
        araddr  <= idx << 2;
        arvalid <= 1'b1;
        exp_rd_q.push_back(expect_read(idx));
        exp_idx_q.push_back(idx);
        do @(negedge clk); while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        do @(negedge clk); while (!(rvalid && rready));
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // random stalls on the response channels
    always @(posedge clk) begin : ready_drive
        logic [31:0] rnd;
        if (bp_en) begin
            rnd = next_rand();
            bready <= rnd[31];
            rready <= rnd[30];
        end else begin
            bready <= 1'b1;
            rready <= 1'b1;
        end
    end

    always @(negedge clk) begin : compare
        if (rstn) begin
            if (rvalid && rready) begin
                assert (exp_rd_q.size() > 0) else begin
                    errors++;
                    $display("Read data returned at %0t with no read outstanding", $time);
                end
                if (exp_rd_q.size() > 0) begin
                    check_value($sformatf("s_rdata_o idx %0d", exp_idx_q.pop_front()),
                                64'(rdata), 64'(exp_rd_q.pop_front()));
                    check_value("s_rresp_o", 64'(rresp), 64'(0));
                end
            end
            if (bvalid && bready) begin
                check_value("s_bresp_o", 64'(bresp), 64'(0));
            end
            if (bvalid && !bready) begin
                check_value("s_awready_o,s_wready_o", 64'({awready, wready}), 64'(0));
            end
            if (rvalid && !rready) begin
                check_value("s_arready_o", 64'(arready), 64'(0));
            end
            if (cmd_pulse != 4'b0000) begin
                assert (exp_pulse_q.size() > 0) else begin
                    errors++;
                    $display("Command pulse %b at %0t without a command write", cmd_pulse, $time);
                end
                if (exp_pulse_q.size() > 0) begin
                    check_value("command pulses", 64'(cmd_pulse), 64'(exp_pulse_q.pop_front()));
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin : main
        logic [31:0] rnd;
        logic [31:0] data;
        rstn    = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b1;
        bp_en   = 1'b0;
        checks  = 0;
        errors  = 0;
        for (int k = 0; k < 4; k++) begin
            status[k] = '0;
        end
        for (int i = 0; i < 12; i++) begin
            model[i] = '0;
        end
        model[`RR_ON_THE_FLY_BALANCE] = `RR_BALANCE_RESET;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_ctrl();
        for (int i = 0; i < `RR_CSR_CNT; i++) begin
            axi_read(i);
        end
        // strobed writes in each channel order
        for (int order = 0; order < 3; order++) begin
            for (int i = 0; i <= `RR_ON_THE_FLY_BALANCE; i++) begin
                if (i < `RECORD_BUF_UPDATE || i == `RR_ON_THE_FLY_BALANCE) begin
                    rnd  = next_rand();
                    data = next_rand();
                    axi_write(i, data, rnd[31:28], order);
                    axi_read(i);
                end
            end
        end
        for (int i = `RECORD_BUF_UPDATE; i <= `VALIDATE_BUF_UPDATE; i++) begin
            axi_write(i, next_rand(), 4'hf, i % 3);
        end
        // status values held long enough to pass the input stage
        for (int r = 0; r < 4; r++) begin
            @(posedge clk);
            for (int k = 0; k < 4; k++) begin
                status[k] <= {next_rand(), next_rand()};
            end
            repeat (4) @(posedge clk);
            for (int i = `RR_CSR_VERSION; i <= `RR_STATE_HI; i++) begin
                axi_read(i);
            end
        end
        @(negedge clk);
        bp_en = 1'b1;
        for (int n = 0; n < N_RAND; n++) begin
            rnd  = next_rand();
            data = next_rand();
            axi_write(int'(rnd[31:27]), data, rnd[24:21], int'(rnd[26:25]) % 3);
            rnd = next_rand();
            axi_read(int'(rnd[31:27]));
        end
        @(negedge clk);
        bp_en = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        assert (exp_rd_q.size() == 0 && exp_pulse_q.size() == 0) else begin
            errors++;
            $display("%0d reads and %0d command pulses never arrived",
                     exp_rd_q.size(), exp_pulse_q.size());
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
